// File: verilog/pe_pkg.sv
`default_nettype none

package pe_pkg;

    // datapath widths
    parameter int WORD_W  = 8;
    parameter int COORD_W = 8;
    parameter int CNT_W   = 16;

    // array shape
    parameter int LANES = 4;
    parameter int ROWS  = 4;

    // input register depth in beats
    parameter int IN_DELAY = 2;

    typedef logic signed [WORD_W-1:0]   word_t;
    typedef logic signed [COORD_W-1:0]  coord_t;
    typedef logic signed [2*WORD_W-1:0] prod_t;
    typedef logic [CNT_W-1:0]           cnt_t;
    typedef logic [1:0]                 slot_t;

    // pass sequencing
    typedef enum logic [1:0] {
        idle        = 2'd0,
        load_weight = 2'd1,
        stream      = 2'd2,
        done        = 2'd3
    } pe_state_t;

endpackage

`default_nettype wire

// File: verilog/beat_delay.sv
`default_nettype none

module beat_delay #(
    parameter int  DEPTH = 2,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  T     d,
    output T     q
);

    T stage [DEPTH];

    // chain moves only on accepted beats
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (in_valid) begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: verilog/pe_ctrl.sv
`default_nettype none

module pe_ctrl #(
    parameter int DEPTH = pe_pkg::IN_DELAY
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  pe_pkg::cnt_t  pass_beats,
    input  pe_pkg::cnt_t  pass_count,
    output logic          weight_we,
    output pe_pkg::slot_t weight_slot,
    output logic          out_valid
);
    import pe_pkg::*;

    pe_state_t state;
    pe_state_t state_next;
    cnt_t      beat_cnt;
    cnt_t      beat_cnt_next;
    cnt_t      pass_cnt;
    cnt_t      pass_cnt_next;
    logic      last_beat;

    // tags of the beat accepted this cycle
    logic      cur_pass;
    logic      cur_we;
    slot_t     cur_slot;

    logic      pass_pipe [DEPTH];
    logic      we_pipe   [DEPTH];
    slot_t     slot_pipe [DEPTH];

    assign last_beat = (beat_cnt == pass_beats - cnt_t'(1));

    always_comb begin
        state_next    = state;
        beat_cnt_next = beat_cnt;
        pass_cnt_next = pass_cnt;
        case (state)
            idle: begin
                // this beat is pass beat 0
                beat_cnt_next = cnt_t'(1);
                state_next    = load_weight;
            end
            load_weight, stream: begin
                if (last_beat) begin
                    beat_cnt_next = '0;
                    pass_cnt_next = pass_cnt + cnt_t'(1);
                    if (pass_cnt + cnt_t'(1) == pass_count) begin
                        state_next = done;
                    end else begin
                        state_next = idle;
                    end
                end else begin
                    beat_cnt_next = beat_cnt + cnt_t'(1);
                    if (beat_cnt == cnt_t'(ROWS - 1)) begin
                        state_next = stream;
                    end
                end
            end
            default: begin
                // done holds until reset
                state_next = done;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            beat_cnt <= '0;
            pass_cnt <= '0;
        end else if (in_valid) begin
            state    <= state_next;
            beat_cnt <= beat_cnt_next;
            pass_cnt <= pass_cnt_next;
        end
    end

    assign cur_pass = (state != done);
    assign cur_we   = (state == idle) || (state == load_weight);
    assign cur_slot = slot_t'(beat_cnt);

    // tags follow the payload through the input delay
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                pass_pipe[i] <= 1'b0;
                we_pipe[i]   <= 1'b0;
                slot_pipe[i] <= '0;
            end
            out_valid <= 1'b0;
        end else if (in_valid) begin
            pass_pipe[0] <= cur_pass;
            we_pipe[0]   <= cur_we;
            slot_pipe[0] <= cur_slot;
            for (int i = 1; i < DEPTH; i++) begin
                pass_pipe[i] <= pass_pipe[i-1];
                we_pipe[i]   <= we_pipe[i-1];
                slot_pipe[i] <= slot_pipe[i-1];
            end
            // one more beat for the store into slots and window
            out_valid <= pass_pipe[DEPTH-1];
        end
    end

    assign weight_we   = we_pipe[DEPTH-1];
    assign weight_slot = slot_pipe[DEPTH-1];

endmodule

`default_nettype wire

// File: verilog/weight_bank.sv
`default_nettype none

module weight_bank (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  logic                                 weight_we,
    input  pe_pkg::slot_t                        weight_slot,
    input  pe_pkg::word_t                        weight_value,
    input  pe_pkg::coord_t                       weight_col,
    input  pe_pkg::coord_t                       weight_row,
    output pe_pkg::word_t  [pe_pkg::ROWS-1:0]    weights,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0]    weight_cols,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0]    weight_rows
);
    import pe_pkg::*;

    // one slot per array row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < ROWS; r++) begin
                weights[r]     <= '0;
                weight_cols[r] <= '0;
                weight_rows[r] <= '0;
            end
        end else if (in_valid && weight_we) begin
            weights[weight_slot]     <= weight_value;
            weight_cols[weight_slot] <= weight_col;
            weight_rows[weight_slot] <= weight_row;
        end
    end

endmodule

`default_nettype wire

// File: verilog/feature_window.sv
`default_nettype none

module feature_window (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 in_valid,
    input  pe_pkg::word_t  [pe_pkg::LANES-1:0]                   feature_value,
    input  pe_pkg::coord_t [pe_pkg::LANES-1:0]                   feature_cols,
    input  pe_pkg::coord_t [pe_pkg::LANES-1:0]                   feature_rows,
    output pe_pkg::word_t  [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] window_value,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] window_cols,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] window_rows
);
    import pe_pkg::*;

    // group 0 newest, oldest group falls off the top
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window_value <= '0;
            window_cols  <= '0;
            window_rows  <= '0;
        end else if (in_valid) begin
            window_value[0] <= feature_value;
            window_cols[0]  <= feature_cols;
            window_rows[0]  <= feature_rows;
            for (int g = 1; g < ROWS; g++) begin
                window_value[g] <= window_value[g-1];
                window_cols[g]  <= window_cols[g-1];
                window_rows[g]  <= window_rows[g-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pe_array.sv
`default_nettype none

module pe_array (
    input  logic                                                 out_valid,
    input  pe_pkg::word_t  [pe_pkg::ROWS-1:0]                    weights,
    input  pe_pkg::coord_t [pe_pkg::ROWS-1:0]                    weight_cols,
    input  pe_pkg::coord_t [pe_pkg::ROWS-1:0]                    weight_rows,
    input  pe_pkg::word_t  [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] window_value,
    input  pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] window_cols,
    input  pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] window_rows,
    output pe_pkg::prod_t  [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out_cols,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out_rows
);
    import pe_pkg::*;

    // row r pairs weight slot r with window group r
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < LANES; c++) begin
                if (out_valid) begin
                    // full width signed product
                    data_out[r][c] = $signed(weights[r]) * $signed(window_value[r][c]);
                    // offset of feature relative to weight
                    data_out_cols[r][c] = window_cols[r][c] - weight_cols[r];
                    data_out_rows[r][c] = window_rows[r][c] - weight_rows[r];
                end else begin
                    data_out[r][c]      = '0;
                    data_out_cols[r][c] = '0;
                    data_out_rows[r][c] = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pe_unit.sv
`default_nettype none

module pe_unit #(
    parameter int DEPTH = pe_pkg::IN_DELAY
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 in_valid,
    input  pe_pkg::cnt_t                                         pass_beats,
    input  pe_pkg::cnt_t                                         pass_count,
    input  pe_pkg::word_t                                        weight_value,
    input  pe_pkg::coord_t                                       weight_col,
    input  pe_pkg::coord_t                                       weight_row,
    input  pe_pkg::word_t  [pe_pkg::LANES-1:0]                   feature_value,
    input  pe_pkg::coord_t [pe_pkg::LANES-1:0]                   feature_cols,
    input  pe_pkg::coord_t [pe_pkg::LANES-1:0]                   feature_rows,
    input  pe_pkg::cnt_t                                         in_channel,
    output logic                                                 out_valid,
    output pe_pkg::prod_t  [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out_cols,
    output pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out_rows,
    output pe_pkg::cnt_t                                         out_channel
);
    import pe_pkg::*;

    // flat payloads for the delay lines
    typedef logic [WORD_W+2*COORD_W-1:0]         weight_bus_t;
    typedef logic [LANES*(WORD_W+2*COORD_W)-1:0] feature_bus_t;

    weight_bus_t                  weight_bus;
    weight_bus_t                  weight_bus_d;
    feature_bus_t                 feature_bus;
    feature_bus_t                 feature_bus_d;

    word_t                        d_weight_value;
    coord_t                       d_weight_col;
    coord_t                       d_weight_row;
    word_t  [LANES-1:0]           d_feature_value;
    coord_t [LANES-1:0]           d_feature_cols;
    coord_t [LANES-1:0]           d_feature_rows;

    logic                         weight_we;
    slot_t                        weight_slot;
    word_t  [ROWS-1:0]            weights;
    coord_t [ROWS-1:0]            weight_cols;
    coord_t [ROWS-1:0]            weight_rows;
    word_t  [ROWS-1:0][LANES-1:0] window_value;
    coord_t [ROWS-1:0][LANES-1:0] window_cols;
    coord_t [ROWS-1:0][LANES-1:0] window_rows;

    assign weight_bus  = {weight_value, weight_col, weight_row};
    assign feature_bus = {feature_value, feature_cols, feature_rows};
    assign {d_weight_value, d_weight_col, d_weight_row} = weight_bus_d;
    assign {d_feature_value, d_feature_cols, d_feature_rows} = feature_bus_d;

    pe_ctrl #(.DEPTH(DEPTH)) i_ctrl (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .pass_beats(pass_beats), .pass_count(pass_count),
        .weight_we(weight_we), .weight_slot(weight_slot), .out_valid(out_valid)
    );

    beat_delay #(.DEPTH(DEPTH), .T(weight_bus_t)) i_weight_delay (
        .clk(clk), .rst(rst), .in_valid(in_valid), .d(weight_bus), .q(weight_bus_d)
    );

    beat_delay #(.DEPTH(DEPTH), .T(feature_bus_t)) i_feature_delay (
        .clk(clk), .rst(rst), .in_valid(in_valid), .d(feature_bus), .q(feature_bus_d)
    );

    // channel tag rides along with the data
    // one extra stage stands for the store into slots and window
    beat_delay #(.DEPTH(DEPTH + 1), .T(cnt_t)) i_channel_delay (
        .clk(clk), .rst(rst), .in_valid(in_valid), .d(in_channel), .q(out_channel)
    );

    weight_bank i_weight_bank (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .weight_we(weight_we), .weight_slot(weight_slot),
        .weight_value(d_weight_value), .weight_col(d_weight_col), .weight_row(d_weight_row),
        .weights(weights), .weight_cols(weight_cols), .weight_rows(weight_rows)
    );

    feature_window i_feature_window (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .feature_value(d_feature_value), .feature_cols(d_feature_cols),
        .feature_rows(d_feature_rows),
        .window_value(window_value), .window_cols(window_cols), .window_rows(window_rows)
    );

    pe_array i_array (
        .out_valid(out_valid),
        .weights(weights), .weight_cols(weight_cols), .weight_rows(weight_rows),
        .window_value(window_value), .window_cols(window_cols), .window_rows(window_rows),
        .data_out(data_out), .data_out_cols(data_out_cols), .data_out_rows(data_out_rows)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: bench/pe_unit_chk.sv
`default_nettype none

module pe_unit_chk (
    input logic                                                 clk,
    input logic                                                 rst,
    input logic                                                 in_valid,
    input logic                                                 out_valid,
    input pe_pkg::prod_t  [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out,
    input pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out_cols,
    input pe_pkg::coord_t [pe_pkg::ROWS-1:0][pe_pkg::LANES-1:0] data_out_rows,
    input pe_pkg::cnt_t                                         out_channel
);
    timeunit 1ns;
    timeprecision 100ps;

    // nothing leaves reset valid
    a_reset_quiet: assert property (@(posedge clk) rst |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    // array is gated to zero when invalid
    a_gated_zero: assert property (@(posedge clk) !out_valid |->
        (data_out == '0 && data_out_cols == '0 && data_out_rows == '0))
        else $error("data outputs nonzero while out_valid is low");

    // a stalled cycle must not move anything
    a_stall_hold: assert property (@(posedge clk) disable iff (rst) !in_valid |=>
        ($stable(out_valid) && $stable(data_out) && $stable(data_out_cols) &&
         $stable(data_out_rows) && $stable(out_channel)))
        else $error("outputs changed after a cycle without in_valid");

endmodule

bind pe_unit pe_unit_chk i_chk (.*);

`default_nettype wire

// File: bench/tb_pe_unit.sv
`default_nettype none

module tb_pe_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import pe_pkg::*;

    // golden file holds header words then one row of fields per beat
    localparam int HDR      = 3;
    localparam int FIELDS   = 21;
    localparam int MAX_ROWS = 20;

    logic [15:0] golden [0:HDR+MAX_ROWS*FIELDS-1];

    logic                         clk;
    logic                         rst;
    logic                         in_valid;
    cnt_t                         pass_beats;
    cnt_t                         pass_count;
    word_t                        weight_value;
    coord_t                       weight_col;
    coord_t                       weight_row;
    word_t  [LANES-1:0]           feature_value;
    coord_t [LANES-1:0]           feature_cols;
    coord_t [LANES-1:0]           feature_rows;
    cnt_t                         in_channel;
    logic                         out_valid;
    prod_t  [ROWS-1:0][LANES-1:0] data_out;
    coord_t [ROWS-1:0][LANES-1:0] data_out_cols;
    coord_t [ROWS-1:0][LANES-1:0] data_out_rows;
    cnt_t                         out_channel;

    int n_rows      = 0;
    int error_count = 0;
    int check_count = 0;

    tb_clock #(.PERIOD_NS(8)) i_clock (.clk(clk));

    pe_unit #(.DEPTH(IN_DELAY)) i_dut (.*);

    task automatic check_value(
        input string       name,
        input int          width,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        logic [31:0] mask;
        mask = (32'd1 << width) - 32'd1;
        check_count++;
        if ((expected & mask) != (actual & mask)) begin
            error_count++;
            $display("Fail %s expected 0x%0h got 0x%0h at %0t",
                     name, expected & mask, actual & mask, $time);
        end
    endtask

    task automatic drive_beat(input int k);
        int base;
        base = HDR + k * FIELDS;
        in_valid     <= 1'b1;
        weight_value <= word_t'(golden[base]);
        weight_col   <= coord_t'(golden[base + 1]);
        weight_row   <= coord_t'(golden[base + 2]);
        for (int c = 0; c < LANES; c++) begin
            feature_value[c] <= word_t'(golden[base + 3 + c]);
            feature_cols[c]  <= coord_t'(golden[base + 7 + c]);
            feature_rows[c]  <= coord_t'(golden[base + 11 + c]);
        end
        in_channel <= golden[base + 15];
    endtask

    // expected element after beat k from the golden stimulus
    task automatic model_element(
        input  int     k,
        input  int     r,
        input  int     c,
        input  logic   valid,
        output prod_t  prod,
        output coord_t col,
        output coord_t row
    );
        int     src;
        int     pass_total;
        word_t  w;
        coord_t w_col;
        coord_t w_row;
        word_t  f;
        coord_t f_col;
        coord_t f_row;
        w          = '0;
        w_col      = '0;
        w_row      = '0;
        f          = '0;
        f_col      = '0;
        f_row      = '0;
        pass_total = int'(pass_beats) * int'(pass_count);
        // slot r keeps the latest stored weight of pass beat r
        for (int i = 0; i <= k - 2; i++) begin
            if (i < pass_total && i % int'(pass_beats) == r) begin
                w     = word_t'(golden[HDR + i * FIELDS]);
                w_col = coord_t'(golden[HDR + i * FIELDS + 1]);
                w_row = coord_t'(golden[HDR + i * FIELDS + 2]);
            end
        end
        // window group r holds the features of beat k-2-r
        src = k - 2 - r;
        if (src >= 0) begin
            f     = word_t'(golden[HDR + src * FIELDS + 3 + c]);
            f_col = coord_t'(golden[HDR + src * FIELDS + 7 + c]);
            f_row = coord_t'(golden[HDR + src * FIELDS + 11 + c]);
        end
        if (valid) begin
            prod = prod_t'(w) * prod_t'(f);
            col  = f_col - w_col;
            row  = f_row - w_row;
        end else begin
            prod = '0;
            col  = '0;
            row  = '0;
        end
    endtask

    // k below zero means the state straight after reset
    task automatic check_outputs(input int k);
        int     base;
        logic   exp_valid;
        cnt_t   exp_channel;
        prod_t  exp_prod;
        coord_t exp_col;
        coord_t exp_row;
        prod_t  m_prod;
        coord_t m_col;
        coord_t m_row;
        exp_valid   = 1'b0;
        exp_channel = '0;
        exp_prod    = '0;
        exp_col     = '0;
        exp_row     = '0;
        if (k >= 0) begin
            base        = HDR + k * FIELDS;
            exp_valid   = golden[base + 16][0];
            exp_channel = golden[base + 17];
            exp_prod    = prod_t'(golden[base + 18]);
            exp_col     = coord_t'(golden[base + 19]);
            exp_row     = coord_t'(golden[base + 20]);
        end
        check_value("out_valid", 1, 32'(exp_valid), 32'(out_valid));
        check_value("out_channel", CNT_W, 32'(exp_channel), 32'(out_channel));
        check_value("data_out[0][0]", 2 * WORD_W, 32'(exp_prod), 32'(data_out[0][0]));
        check_value("data_out_cols[0][0]", COORD_W, 32'(exp_col), 32'(data_out_cols[0][0]));
        check_value("data_out_rows[0][0]", COORD_W, 32'(exp_row), 32'(data_out_rows[0][0]));
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < LANES; c++) begin
                model_element(k, r, c, exp_valid, m_prod, m_col, m_row);
                check_value($sformatf("data_out[%0d][%0d]", r, c), 2 * WORD_W,
                            32'(m_prod), 32'(data_out[r][c]));
                check_value($sformatf("data_out_cols[%0d][%0d]", r, c), COORD_W,
                            32'(m_col), 32'(data_out_cols[r][c]));
                check_value($sformatf("data_out_rows[%0d][%0d]", r, c), COORD_W,
                            32'(m_row), 32'(data_out_rows[r][c]));
            end
        end
    endtask

    initial begin
        int gap;
        void'($urandom(83693));
        $readmemh("bench/pe_golden.hex", golden);
        rst           = 1'b1;
        in_valid      = 1'b0;
        pass_beats    = golden[0];
        pass_count    = golden[1];
        weight_value  = '0;
        weight_col    = '0;
        weight_row    = '0;
        feature_value = '0;
        feature_cols  = '0;
        feature_rows  = '0;
        in_channel    = '0;
        n_rows        = int'(golden[2]);
        if (n_rows < 1 || n_rows > MAX_ROWS) begin
            $display("golden file is missing or its row count is out of range");
            error_count++;
            n_rows = 0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // each iteration checks the result of the beat before it
        for (int k = 0; k <= n_rows; k++) begin
            gap = int'($urandom_range(2, 0));
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
                @(negedge clk);
                check_outputs(k - 1);
            end
            @(posedge clk);
            if (k < n_rows) begin
                drive_beat(k);
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            check_outputs(k - 1);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // a row takes at most three cycles
    initial begin
        wait (n_rows > 0);
        repeat (n_rows * 20) @(posedge clk);
        $display("timeout: the golden rows were not all checked in time");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/pe_pkg.sv
verilog/beat_delay.sv
verilog/pe_ctrl.sv
verilog/weight_bank.sv
verilog/feature_window.sv
verilog/pe_array.sv
verilog/pe_unit.sv
bench/tb_clock.sv
bench/pe_unit_chk.sv
bench/tb_pe_unit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pe_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pe_unit -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_pe_unit)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: bench/pe_golden.hex
// header: pass_beats pass_count rows
// row: wv wcol wrow fv0..fv3 fcol0..fcol3 frow0..frow3 chan
//      then after that beat: valid chan_out data_out[0][0] cols[0][0] rows[0][0]
0005 0003 0014
03 00 f0 01 ff 20 e0 00 10 20 30 c0 c4 c8 cc a000 0 0000 0000 00 00
fe 01 f1 02 fe 21 e1 01 11 21 31 c1 c5 c9 cd a001 0 0000 0000 00 00
05 02 f2 03 fd 22 e2 02 12 22 32 c2 c6 ca ce a002 1 a000 0003 00 d0
f9 03 f3 04 fc 23 e3 03 13 23 33 c3 c7 cb cf a003 1 a001 0006 01 d1
11 04 f4 05 fb 24 e4 04 14 24 34 c4 c8 cc d0 a004 1 a002 0009 02 d2
fc 05 f5 06 fa 25 e5 05 15 25 35 c5 c9 cd d1 a005 1 a003 000c 03 d3
02 06 f6 07 f9 26 e6 06 16 26 36 c6 ca ce d2 a006 1 a004 000f 04 d4
7f 07 f7 08 f8 27 e7 07 17 27 37 c7 cb cf d3 a007 1 a005 ffe8 00 d0
80 08 f8 09 f7 28 e8 08 18 28 38 c8 cc d0 d4 a008 1 a006 ffe4 01 d1
22 09 f9 0a f6 29 e9 09 19 29 39 c9 cd d1 d5 a009 1 a007 ffe0 02 d2
06 0a fa 0b f5 2a ea 0a 1a 2a 3a ca ce d2 d6 a00a 1 a008 ffdc 03 d3
fd 0b fb 0c f4 2b eb 0b 1b 2b 3b cb cf d3 d7 a00b 1 a009 ffd8 04 d4
01 0c fc 0d f3 2c ec 0c 1c 2c 3c cc d0 d4 d8 a00c 1 a00a 0042 00 d0
0a 0d fd 0e f2 2d ed 0d 1d 2d 3d cd d1 d5 d9 a00d 1 a00b 0048 01 d1
33 0e fe 0f f1 2e ee 0e 1e 2e 3e ce d2 d6 da a00e 1 a00c 004e 02 d2
44 0f ff 10 f0 2f ef 0f 1f 2f 3f cf d3 d7 db a00f 1 a00d 0054 03 d3
55 10 00 11 ef 30 f0 10 20 30 40 d0 d4 d8 dc a010 1 a00e 005a 04 d4
66 11 01 12 ee 31 f1 11 21 31 41 d1 d5 d9 dd a011 0 a00f 0000 00 00
77 12 02 13 ed 32 f2 12 22 32 42 d2 d6 da de a012 0 a010 0000 00 00
12 13 03 14 ec 33 f3 13 23 33 43 d3 d7 db df a013 0 a011 0000 00 00
